// File: sources.f
+incdir+.
fcore_decode_pkg.sv
instr_field_extract.sv
decode_fifo.sv
issue_unit.sv
fcore_decoder_top.sv
fcore_decoder_tb.sv

// File: decoder_vectors.svh
/*
 * Decoder test vectors.
 * Columns: instruction word, expected opcode, operand A and B as
 * (source kind, selector or literal, target selector), operation, stop.
 */
`ifndef DECODER_VECTORS_SVH
`define DECODER_VECTORS_SVH

// Source kinds of an expected operand
localparam logic [1:0] S_NONE = 2'd0;
localparam logic [1:0] S_REG  = 2'd1;
localparam logic [1:0] S_IMM  = 2'd2;
localparam logic [1:0] S_LD   = 2'd3;

typedef struct packed {
    logic [1:0]               kind;
    logic [11:0]              value;
    logic [REG_SEL_WIDTH-1:0] target_sel;
} operand_vec_t;

typedef struct packed {
    logic [INSTR_WIDTH-1:0] instr;
    opcode_e                opcode;
    operand_vec_t           a;
    operand_vec_t           b;
    operation_req_t         op;
    logic                   stop;
} vector_t;

localparam operand_vec_t   NO_OPND     = '0;
localparam operation_req_t NO_OP       = '0;
localparam int             NUM_VECTORS = 16;

vector_t vectors [NUM_VECTORS] = '{
    '{16'h3211, ADD, '{S_REG, 12'h1, 4'h3}, '{S_REG, 12'h2, 4'h3}, '{1'b1, OP_ADD}, 1'b0},
    '{16'h7542, SUB, '{S_REG, 12'h4, 4'h7}, '{S_REG, 12'h5, 4'h7}, '{1'b1, OP_SUB}, 1'b0},
    '{16'hA983, MUL, '{S_REG, 12'h8, 4'hA}, '{S_REG, 12'h9, 4'h9}, NO_OP, 1'b0},
    '{16'h1FE7, BGT, '{S_REG, 12'hE, 4'h1}, '{S_REG, 12'hF, 4'h1}, '{1'b1, OP_BGT}, 1'b0},
    '{16'h0CD8, BLE, '{S_REG, 12'hD, 4'h0}, '{S_REG, 12'hC, 4'h0}, '{1'b1, OP_BLE}, 1'b0},
    '{16'h6669, BEQ, '{S_REG, 12'h6, 4'h6}, '{S_REG, 12'h6, 4'h6}, '{1'b1, OP_BEQ}, 1'b0},
    '{16'hB42A, BNE, '{S_REG, 12'h2, 4'hB}, '{S_REG, 12'h4, 4'hB}, '{1'b1, OP_BNE}, 1'b0},
    '{16'h0534, REC, '{S_REG, 12'h3, 4'h5}, NO_OPND, NO_OP, 1'b0},
    '{16'h089B, ABS, '{S_REG, 12'h9, 4'h8}, NO_OPND, '{1'b1, OP_ABS}, 1'b0},
    '{16'h01FC, POPCNT, '{S_REG, 12'hF, 4'h1}, NO_OPND, '{1'b1, OP_POPCNT}, 1'b0},
    '{16'h0E7D, LNOT, '{S_REG, 12'h7, 4'hE}, NO_OPND, '{1'b1, OP_LNOT}, 1'b0},
    '{16'hABC5, LDR, '{S_IMM, 12'hABC, 4'hC}, NO_OPND, NO_OP, 1'b0},
    '{16'h0096, LDC, '{S_LD, 12'h0, 4'h9}, NO_OPND, NO_OP, 1'b0},
    '{16'h000E, STOP, NO_OPND, NO_OPND, NO_OP, 1'b1},
    '{16'h1230, NOP, NO_OPND, NO_OPND, NO_OP, 1'b0},
    '{16'h456F, RSVD, NO_OPND, NO_OPND, NO_OP, 1'b0}
};

`endif

// File: fcore_decoder_tb.sv
/*
 * Testbench for the control core instruction decoder.
 * Applies a table of instructions on random channels, checks issued
 * requests in order and exercises buffering while issue is held off.
 */
`timescale 1ns/100ps

module fcore_decoder_tb;
    import fcore_decode_pkg::*;

    `include "decoder_vectors.svh"

    localparam int TIMEOUT_CYCLES = 20 * NUM_VECTORS + 50;

    typedef struct packed {
        opcode_e        opcode;
        operand_req_t   operand_a;
        operand_req_t   operand_b;
        operation_req_t operation;
        logic           stop;
    } expect_t;

    logic                     clock = 1'b0;
    logic                     arst_n;
    logic                     enable;
    logic                     instr_valid;
    logic [INSTR_WIDTH-1:0]   instr;
    logic [CHANNEL_WIDTH-1:0] channel;
    logic [DATA_WIDTH-1:0]    load_data;
    logic                     instr_full;
    operand_req_t             operand_a;
    operand_req_t             operand_b;
    operation_req_t           operation;
    opcode_e                  exec_opcode;
    logic                     core_stop;

    expect_t expected_q[$];
    int      cycle_count = 0;

    fcore_decoder_top #(.FIFO_DEPTH(4)) i_fcore_decoder_top (.*);

    always #20 clock = ~clock;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Absolute address is the channel times 16 plus the selector
    function automatic operand_req_t expand_operand(input operand_vec_t v,
                                                    input logic [CHANNEL_WIDTH-1:0] chan,
                                                    input logic [DATA_WIDTH-1:0] data);
        operand_req_t req;
        req.valid  = (v.kind != S_NONE);
        req.target = REG_ADDR_WIDTH'(chan * 16 + v.target_sel);
        case (v.kind)
            S_REG:   req.source = DATA_WIDTH'(chan * 16 + v.value);
            S_LD:    req.source = data;
            default: req.source = DATA_WIDTH'(v.value);
        endcase
        return req;
    endfunction

    task automatic step_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic send_instr(input int row);
        logic [CHANNEL_WIDTH-1:0] chan;
        logic [DATA_WIDTH-1:0]    data;
        expect_t                  want;
        chan = CHANNEL_WIDTH'($urandom());
        data = DATA_WIDTH'($urandom());
        want.opcode    = vectors[row].opcode;
        want.operand_a = expand_operand(vectors[row].a, chan, data);
        want.operand_b = expand_operand(vectors[row].b, chan, data);
        want.operation = vectors[row].op;
        want.stop      = vectors[row].stop;
        if (want.operand_a.valid || want.operand_b.valid
                || want.operation.valid || want.stop) begin
            expected_q.push_back(want);
        end
        instr_valid = 1'b1;
        instr       = vectors[row].instr;
        channel     = chan;
        load_data   = data;
        step_cycle();
        instr_valid = 1'b0;
    endtask

    // Silent opcodes are seen only through exec_opcode
    task automatic wait_issue(input int row);
        if (vectors[row].a.kind != S_NONE || vectors[row].stop) begin
            while (expected_q.size() != 0) step_cycle();
        end else begin
            while (exec_opcode != vectors[row].opcode) step_cycle();
        end
    endtask

    // Outputs change on the rising edge and are sampled on the falling edge
    always @(negedge clock) begin : monitor
        expect_t want;
        if (arst_n && (operand_a.valid || operand_b.valid || operation.valid || core_stop)) begin
            if (expected_q.size() == 0) begin
                $display("Request pulse at %0t ns with no instruction outstanding", $time);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                want = expected_q.pop_front();
                check_value("exec_opcode", exec_opcode, want.opcode);
                check_value("core_stop", core_stop, want.stop);
                check_value("operand_a.valid", operand_a.valid, want.operand_a.valid);
                check_value("operand_b.valid", operand_b.valid, want.operand_b.valid);
                check_value("operation.valid", operation.valid, want.operation.valid);
                if (want.operand_a.valid) begin
                    check_value("operand_a", operand_a, want.operand_a);
                end
                if (want.operand_b.valid) begin
                    check_value("operand_b", operand_b, want.operand_b);
                end
                if (want.operation.valid) begin
                    check_value("operation", operation, want.operation);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(53712));
        arst_n      = 1'b0;
        enable      = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        channel     = '0;
        load_data   = '0;
        repeat (3) @(posedge clock);
        #2;
        arst_n = 1'b1;

        repeat (5) begin
            step_cycle();
            check_value("idle exec_opcode", exec_opcode, NOP);
            check_value("idle pulses", {operand_a.valid, operand_b.valid,
                                        operation.valid, core_stop}, 4'b0000);
        end

        for (int row = 0; row < NUM_VECTORS; row++) begin
            send_instr(row);
            wait_issue(row);
        end

        // Three entries pile up while issue is held off
        enable = 1'b0;
        for (int row = 0; row < 3; row++) begin
            send_instr(row);
        end
        repeat (2) step_cycle();
        check_value("instr_full while held", instr_full, 1'b1);
        check_value("entries outstanding", expected_q.size(), 3);

        // Buffered entries drain at one per cycle once issue resumes
        enable = 1'b1;
        repeat (4) step_cycle();
        check_value("instr_full after drain", instr_full, 1'b0);

        if (expected_q.size() != 0) begin
            $display("Run ended with %0d expected requests never issued", expected_q.size());
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: fcore_decoder_top.sv
/*
 * Instruction decoder of the multichannel control core.
 * Field extraction, a decoded entry FIFO and the issue unit in series.
 */
`timescale 1ns/100ps

module fcore_decoder_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                      clock,
    input  logic                                      arst_n,
    input  logic                                      enable,
    input  logic                                      instr_valid,
    input  logic [fcore_decode_pkg::INSTR_WIDTH-1:0]   instr,
    input  logic [fcore_decode_pkg::CHANNEL_WIDTH-1:0] channel,
    input  logic [fcore_decode_pkg::DATA_WIDTH-1:0]    load_data,
    output logic                                      instr_full,
    output fcore_decode_pkg::operand_req_t            operand_a,
    output fcore_decode_pkg::operand_req_t            operand_b,
    output fcore_decode_pkg::operation_req_t          operation,
    output fcore_decode_pkg::opcode_e                 exec_opcode,
    output logic                                      core_stop
);
    import fcore_decode_pkg::*;

    decoded_instr_t entry;
    decoded_instr_t head;
    logic           entry_valid;
    logic           empty;
    logic           pop;

    instr_field_extract i_instr_field_extract (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .channel     (channel),
        .load_data   (load_data),
        .entry       (entry),
        .entry_valid (entry_valid)
    );

    decode_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_decode_fifo (
        .clock       (clock),
        .arst_n      (arst_n),
        .entry_valid (entry_valid),
        .entry       (entry),
        .pop         (pop),
        .head        (head),
        .empty       (empty),
        .instr_full  (instr_full)
    );

    issue_unit i_issue_unit (
        .clock       (clock),
        .arst_n      (arst_n),
        .enable      (enable),
        .head        (head),
        .empty       (empty),
        .pop         (pop),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .operation   (operation),
        .exec_opcode (exec_opcode),
        .core_stop   (core_stop)
    );

endmodule

// File: issue_unit.sv
/*
 * Issue unit.
 * Pops one decoded entry per cycle while enabled and turns it into
 * operand, operation and stop requests for the execution unit.
 */
`timescale 1ns/100ps

module issue_unit (
    input  logic                             clock,
    input  logic                             arst_n,
    input  logic                             enable,
    input  fcore_decode_pkg::decoded_instr_t head,
    input  logic                             empty,
    output logic                             pop,
    output fcore_decode_pkg::operand_req_t   operand_a,
    output fcore_decode_pkg::operand_req_t   operand_b,
    output fcore_decode_pkg::operation_req_t operation,
    output fcore_decode_pkg::opcode_e        exec_opcode,
    output logic                             core_stop
);
    import fcore_decode_pkg::*;

    localparam int ADDR_PAD = DATA_WIDTH - REG_ADDR_WIDTH;
    localparam int IMM_PAD  = DATA_WIDTH - IMM_WIDTH;

    operand_req_t   nxt_a;
    operand_req_t   nxt_b;
    operation_req_t nxt_op;
    logic           nxt_stop;

    logic                      a_valid;
    logic                      b_valid;
    logic                      op_valid;
    logic [DATA_WIDTH-1:0]     a_source;
    logic [REG_ADDR_WIDTH-1:0] a_target;
    logic [DATA_WIDTH-1:0]     b_source;
    logic [REG_ADDR_WIDTH-1:0] b_target;
    alu_op_e                   op_code;

    assign pop = enable && !empty;

    always_comb begin
        nxt_a        = '0;
        nxt_b        = '0;
        nxt_op       = '0;
        nxt_stop     = 1'b0;
        nxt_a.source = {{ADDR_PAD{1'b0}}, head.reg_a};
        nxt_a.target = head.reg_dest;
        nxt_b.source = {{ADDR_PAD{1'b0}}, head.reg_b};
        nxt_b.target = head.reg_dest;
        case (head.opcode)
            ADD, SUB, BGT, BLE, BEQ, BNE: begin
                nxt_a.valid  = 1'b1;
                nxt_b.valid  = 1'b1;
                nxt_op.valid = 1'b1;
                case (head.opcode)
                    ADD:     nxt_op.code = OP_ADD;
                    SUB:     nxt_op.code = OP_SUB;
                    BGT:     nxt_op.code = OP_BGT;
                    BLE:     nxt_op.code = OP_BLE;
                    BEQ:     nxt_op.code = OP_BEQ;
                    default: nxt_op.code = OP_BNE;
                endcase
            end
            MUL: begin
                // The multiplier takes its second target from reg_b
                nxt_a.valid  = 1'b1;
                nxt_b.valid  = 1'b1;
                nxt_b.target = head.reg_b;
            end
            REC: begin
                nxt_a.valid  = 1'b1;
                nxt_a.target = head.reg_b;
            end
            ABS, POPCNT, LNOT: begin
                nxt_a.valid  = 1'b1;
                nxt_a.target = head.reg_b;
                nxt_op.valid = 1'b1;
                case (head.opcode)
                    ABS:     nxt_op.code = OP_ABS;
                    POPCNT:  nxt_op.code = OP_POPCNT;
                    default: nxt_op.code = OP_LNOT;
                endcase
            end
            LDR: begin
                nxt_a.valid  = 1'b1;
                nxt_a.source = {{IMM_PAD{1'b0}}, head.imm};
                nxt_a.target = head.reg_a;
            end
            LDC: begin
                nxt_a.valid  = 1'b1;
                nxt_a.source = head.load_data;
                nxt_a.target = head.reg_a;
            end
            STOP: begin
                nxt_stop = 1'b1;
            end
            default: begin
                // NOP and the spare opcode issue no requests
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            a_valid     <= 1'b0;
            b_valid     <= 1'b0;
            op_valid    <= 1'b0;
            core_stop   <= 1'b0;
            exec_opcode <= NOP;
        end else begin
            a_valid   <= pop && nxt_a.valid;
            b_valid   <= pop && nxt_b.valid;
            op_valid  <= pop && nxt_op.valid;
            core_stop <= pop && nxt_stop;
            if (pop) begin
                exec_opcode <= head.opcode;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            a_source <= nxt_a.source;
            a_target <= nxt_a.target;
            b_source <= nxt_b.source;
            b_target <= nxt_b.target;
            op_code  <= nxt_op.code;
        end
    end

    assign operand_a = '{valid: a_valid, source: a_source, target: a_target};
    assign operand_b = '{valid: b_valid, source: b_source, target: b_target};
    assign operation = '{valid: op_valid, code: op_code};

    // A stop pulse halts the core and never comes with an operand request
    a_stop_alone: assert property (
        @(posedge clock) disable iff (!arst_n)
        core_stop |-> !operand_a.valid && !operand_b.valid
    ) else $error("issue_unit: stop issued together with an operand request");

endmodule

// File: decode_fifo.sv
/*
 * Decoded instruction FIFO.
 * Circular buffer between field extraction and issue, so that
 * instructions keep arriving while issue is held off.
 */
`timescale 1ns/100ps

module decode_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clock,
    input  logic                             arst_n,
    input  logic                             entry_valid,
    input  fcore_decode_pkg::decoded_instr_t entry,
    input  logic                             pop,
    output fcore_decode_pkg::decoded_instr_t head,
    output logic                             empty,
    output logic                             instr_full
);
    import fcore_decode_pkg::*;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    decoded_instr_t mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    // Pointers wrap explicitly so that depths other than powers of two work
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (entry_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (entry_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !entry_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (entry_valid) begin
            mem[wr_ptr] <= entry;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    // One slot is kept back for the entry still sitting in the extract register
    assign instr_full = (count >= CNT_WIDTH'(FIFO_DEPTH - 1));

    a_no_overflow: assert property (
        @(posedge clock) disable iff (!arst_n)
        entry_valid |-> (count < CNT_WIDTH'(FIFO_DEPTH))
    ) else $error("decode_fifo: push into a full FIFO");

    a_no_underflow: assert property (
        @(posedge clock) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("decode_fifo: pop from an empty FIFO");

endmodule

// File: instr_field_extract.sv
/*
 * Instruction field extraction.
 * Slices a sampled instruction word and turns its register selectors
 * into absolute register file addresses within the given channel.
 */
`timescale 1ns/100ps

module instr_field_extract (
    input  logic                                      clock,
    input  logic                                      arst_n,
    input  logic                                      instr_valid,
    input  logic [fcore_decode_pkg::INSTR_WIDTH-1:0]   instr,
    input  logic [fcore_decode_pkg::CHANNEL_WIDTH-1:0] channel,
    input  logic [fcore_decode_pkg::DATA_WIDTH-1:0]    load_data,
    output fcore_decode_pkg::decoded_instr_t          entry,
    output logic                                      entry_valid
);
    import fcore_decode_pkg::*;

    logic [REG_SEL_WIDTH-1:0] sel_a;
    logic [REG_SEL_WIDTH-1:0] sel_b;
    logic [REG_SEL_WIDTH-1:0] sel_dest;

    assign sel_a    = instr[SEL_A_LSB +: REG_SEL_WIDTH];
    assign sel_b    = instr[SEL_B_LSB +: REG_SEL_WIDTH];
    assign sel_dest = instr[SEL_D_LSB +: REG_SEL_WIDTH];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= instr_valid;
        end
    end

    // Channel number sits above the selector, so each channel owns 16 registers
    always_ff @(posedge clock) begin
        if (instr_valid) begin
            entry.opcode    <= opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
            entry.reg_a     <= {channel, sel_a};
            entry.reg_b     <= {channel, sel_b};
            entry.reg_dest  <= {channel, sel_dest};
            entry.imm       <= instr[IMM_LSB +: IMM_WIDTH];
            entry.load_data <= load_data;
        end
    end

    // An unknown opcode would be pushed into the FIFO and issue as garbage
    a_opcode_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        instr_valid |-> !$isunknown(instr[OPCODE_LSB +: OPCODE_WIDTH])
    ) else $error("instr_field_extract: unknown opcode on a valid instruction");

endmodule

// File: fcore_decode_pkg.sv
/*
 * Shared definitions for the control core instruction decoder.
 * Field widths, instruction layout, opcode and operation encodings,
 * and the structs passed between extraction, buffer and issue.
 */
package fcore_decode_pkg;

    localparam int INSTR_WIDTH    = 16;
    localparam int OPCODE_WIDTH   = 4;
    localparam int REG_SEL_WIDTH  = 4;
    localparam int CHANNEL_WIDTH  = 8;
    localparam int REG_ADDR_WIDTH = CHANNEL_WIDTH + REG_SEL_WIDTH;
    localparam int IMM_WIDTH      = 12;
    localparam int DATA_WIDTH     = 16;

    // Bit positions of the fields inside an instruction word
    localparam int OPCODE_LSB = 0;
    localparam int SEL_A_LSB  = 4;
    localparam int SEL_B_LSB  = 8;
    localparam int SEL_D_LSB  = 12;
    localparam int IMM_LSB    = 4;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        MUL    = 4'd3,
        REC    = 4'd4,
        LDR    = 4'd5,
        LDC    = 4'd6,
        BGT    = 4'd7,
        BLE    = 4'd8,
        BEQ    = 4'd9,
        BNE    = 4'd10,
        ABS    = 4'd11,
        POPCNT = 4'd12,
        LNOT   = 4'd13,
        STOP   = 4'd14,
        RSVD   = 4'd15
    } opcode_e;

    // Codes understood by the execution unit, branch codes carry the compare mode
    typedef enum logic [5:0] {
        OP_ADD    = 6'd0,
        OP_SUB    = 6'd1,
        OP_LNOT   = 6'd2,
        OP_POPCNT = 6'd3,
        OP_ABS    = 6'd4,
        OP_BEQ    = 6'd20,
        OP_BLE    = 6'd28,
        OP_BGT    = 6'd36,
        OP_BNE    = 6'd44
    } alu_op_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] reg_a;
        logic [REG_ADDR_WIDTH-1:0] reg_b;
        logic [REG_ADDR_WIDTH-1:0] reg_dest;
        logic [IMM_WIDTH-1:0]      imm;
        logic [DATA_WIDTH-1:0]     load_data;
    } decoded_instr_t;

    typedef struct packed {
        logic                      valid;
        logic [DATA_WIDTH-1:0]     source;
        logic [REG_ADDR_WIDTH-1:0] target;
    } operand_req_t;

    typedef struct packed {
        logic    valid;
        alu_op_e code;
    } operation_req_t;

endpackage
